/* flist.f */
verilog/plic_bus_pkg.sv
verilog/plic_irq_pkg.sv
verilog/plic_reg_slave.sv
verilog/plic_regfile.sv
verilog/plic_gateway.sv
verilog/plic_target.sv
verilog/plic_top.sv
verification/tb_plic.sv

/* verification/tb_plic.sv */
// ##########################################################
// plic testbench
// drives the req/ack port and the sources, mirrors the
// controller state and checks claims, o_ip and handshakes
// ##########################################################
`timescale 1ns/1ps
`default_nettype none

module tb_plic import plic_bus_pkg::*, plic_irq_pkg::*; ();

    localparam int NSRC     = 32;
    localparam int NCTX     = 2;
    localparam int ACCESSES = 160;          // bus accesses over all tests
    localparam int SETTLE   = 250;          // cycles in resets and settle waits

    logic            i_clk;
    logic            i_nrst;
    logic            i_req;
    bus_req_t        i_bus_req;
    logic            o_ack;
    bus_rsp_t        o_bus_rsp;
    logic [NSRC-1:0] i_irq;
    logic [NCTX-1:0] o_ip;

    int          seed;
    int          errors;
    int          test_err;
    prio_t       m_prio [NSRC];             // mirror of the controller state
    logic [31:0] m_en [NCTX];
    prio_t       m_thr [NCTX];
    logic [31:0] m_pend;
    logic [31:0] m_insvc;
    logic        ack_s;
    logic        req_s;
    bus_rsp_t    rsp_s;

    plic_top #(.NUM_SRC(NSRC), .NUM_CTX(NCTX)) DUT (
        .i_clk     (i_clk),
        .i_nrst    (i_nrst),
        .i_req     (i_req),
        .i_bus_req (i_bus_req),
        .o_ack     (o_ack),
        .o_bus_rsp (o_bus_rsp),
        .i_irq     (i_irq),
        .o_ip      (o_ip)
    );

    initial begin
        i_clk = 1'b0;
        forever #5 i_clk = ~i_clk;
    end

    // highest eligible priority wins, a tie goes to the highest id
    function automatic int expected_claim(input int ctx);
        int    best = 0;
        prio_t top  = '0;
        for (int i = 1; i < NSRC; i++) begin
            if (m_pend[i] && m_en[ctx][i] && (m_prio[i] > m_thr[ctx]) && (m_prio[i] >= top)) begin
                top  = m_prio[i];
                best = i;
            end
        end
        return best;
    endfunction

    function automatic logic [NCTX-1:0] expected_ip();
        logic [NCTX-1:0] ip;
        for (int n = 0; n < NCTX; n++) begin
            ip[n] = (expected_claim(n) != 0);
        end
        return ip;
    endfunction

    function automatic logic [15:0] claim_addr(input int ctx);
        return CTX_BASE + CTX_STRIDE * 16'(ctx) + CLAIM_OFS;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("ERROR at %0t ns: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
            errors++;
        end
    endtask

    // handshake monitor sampled on the rising edge before the DUT updates
    always @(posedge i_clk) begin
        if (i_nrst) begin
            if (ack_s && req_s) begin
                check_value("o_ack", o_ack, 1'b1);
                check_value("o_bus_rsp.rdata", o_bus_rsp.rdata, rsp_s.rdata);
                check_value("o_bus_rsp.err", o_bus_rsp.err, rsp_s.err);
            end
            assert (!(i_req && !req_s && o_ack)) else begin
                $display("request at %0t ns was raised while o_ack was still high", $time);
                errors++;
            end
        end
        ack_s <= o_ack;
        req_s <= i_req;
        rsp_s <= o_bus_rsp;
    end

    task automatic bus_access(input logic wr, input logic [15:0] addr, input logic [31:0] wdata,
                              output bus_rsp_t rsp);
        int waited = 0;
        int hold;
        hold = $random(seed) & 3;           // slow master holds i_req a little longer
        @(negedge i_clk);
        i_bus_req = {wr, addr, wdata};
        i_req     = 1'b1;
        while (!o_ack && waited < 10) begin
            @(negedge i_clk);
            waited++;
        end
        check_value("ack latency", waited, 2);
        rsp = o_bus_rsp;
        repeat (hold) @(negedge i_clk);
        i_req  = 1'b0;
        waited = 0;
        while (o_ack && waited < 10) begin
            @(negedge i_clk);
            waited++;
        end
        check_value("ack release", waited, 1);
    endtask

    task automatic bus_write(input logic [15:0] addr, input logic [31:0] data);
        bus_rsp_t rsp;
        bus_access(1'b1, addr, data, rsp);
    endtask

    task automatic bus_read(input logic [15:0] addr, output bus_rsp_t rsp);
        bus_access(1'b0, addr, 32'h0, rsp);
    endtask

    task automatic read_expect(input logic [15:0] addr, input logic [31:0] exp, input string name);
        bus_rsp_t rsp;
        bus_read(addr, rsp);
        check_value(name, rsp.rdata, exp);
        check_value({name, " err"}, rsp.err, 1'b0);
    endtask

    task automatic set_prio(input int i, input logic [31:0] v);
        bus_write(PRIO_BASE + PRIO_STRIDE * 16'(i), v);
        if (i != 0) begin
            m_prio[i] = prio_t'(v);
        end
    endtask

    task automatic set_enable(input int n, input logic [31:0] v);
        bus_write(ENABLE_BASE + ENABLE_STRIDE * 16'(n), v);
        m_en[n] = v & 32'hffff_fffe;        // source 0 does not exist
    endtask

    task automatic set_thr(input int n, input logic [31:0] v);
        bus_write(CTX_BASE + CTX_STRIDE * 16'(n), v);
        m_thr[n] = prio_t'(v);
    endtask

    // let the gateway and the arbiters catch up, then latch pending in the model
    task automatic settle();
        repeat (6) @(negedge i_clk);
        for (int i = 1; i < NSRC; i++) begin
            if (i_irq[i] && !m_insvc[i]) begin
                m_pend[i] = 1'b1;
            end
        end
    endtask

    task automatic claim(input int ctx);
        int exp;
        settle();
        exp = expected_claim(ctx);
        read_expect(claim_addr(ctx), exp, $sformatf("claim ctx%0d", ctx));
        if (exp != 0) begin
            m_pend[exp]  = 1'b0;
            m_insvc[exp] = 1'b1;
        end
    endtask

    task automatic complete(input int ctx, input int id);
        bus_write(claim_addr(ctx), 32'(id));
        m_insvc[id] = 1'b0;
    endtask

    task automatic apply_reset();
        i_nrst    = 1'b0;
        i_req     = 1'b0;
        i_bus_req = '0;
        i_irq     = '0;
        for (int i = 0; i < NSRC; i++) begin
            m_prio[i] = '0;
        end
        for (int n = 0; n < NCTX; n++) begin
            m_en[n]  = '0;
            m_thr[n] = '0;
        end
        m_pend  = '0;
        m_insvc = '0;
        repeat (10) @(negedge i_clk);
        i_nrst = 1'b1;
    endtask

    task automatic report_test(input string name);
        $display("test %s finished with %0d errors", name, errors - test_err);
        test_err = errors;
    endtask

    initial begin
        bus_rsp_t    rsp;
        int          src;
        int          waited;
        seed     = 32'h4c0f;
        errors   = 0;
        test_err = 0;
        apply_reset();

        check_value("o_ack", o_ack, 1'b0);
        check_value("o_ip", o_ip, '0);
        for (int i = 0; i < NSRC; i++) begin
            set_prio(i, $random(seed));
        end
        for (int i = 0; i < NSRC; i++) begin
            read_expect(PRIO_BASE + PRIO_STRIDE * 16'(i), m_prio[i], $sformatf("prio[%0d]", i));
        end
        for (int n = 0; n < NCTX; n++) begin
            set_enable(n, $random(seed));
            set_thr(n, $random(seed));
            read_expect(ENABLE_BASE + ENABLE_STRIDE * 16'(n), m_en[n], "enable");
            read_expect(CTX_BASE + CTX_STRIDE * 16'(n), m_thr[n], "threshold");
        end
        bus_read(16'h4000, rsp);            // hole in the map
        check_value("unmapped rdata", rsp.rdata, 32'h0);
        check_value("unmapped err", rsp.err, 1'b1);
        report_test("1 reset and readback");

        src = 1 + ($random(seed) & 15);
        set_prio(src, 3);
        set_enable(0, 32'h1 << src);
        set_thr(0, 0);
        @(negedge i_clk);
        i_irq[src] = 1'b1;
        waited     = 0;
        while (!o_ip[0] && waited < 6) begin
            @(negedge i_clk);
            waited++;
        end
        check_value("o_ip[0]", o_ip[0], 1'b1);
        claim(0);
        read_expect(PEND_ADDR, m_pend, "pending");
        settle();
        check_value("o_ip", o_ip, expected_ip());
        i_irq[src] = 1'b0;
        complete(0, src);
        report_test("2 single source");

        for (int i = 1; i < NSRC; i++) begin
            set_prio(i, $random(seed));
        end
        set_prio(7, 15);                    // tied top level in context 0
        set_prio(20, 15);
        set_enable(0, $random(seed) | (32'h1 << 7) | (32'h1 << 20));
        set_enable(1, $random(seed));
        set_thr(0, 0);
        set_thr(1, $random(seed) & 7);
        @(negedge i_clk);
        i_irq = $random(seed) | (32'h1 << 7) | (32'h1 << 20);
        for (int r = 0; r < 4; r++) begin
            claim(0);
            claim(1);
        end
        settle();
        check_value("o_ip", o_ip, expected_ip());
        report_test("3 arbitration");

        apply_reset();
        set_prio(3, 2);
        set_prio(9, 4);
        set_enable(0, (32'h1 << 3) | (32'h1 << 9));
        set_thr(0, 4);
        @(negedge i_clk);
        i_irq[3] = 1'b1;
        i_irq[9] = 1'b1;
        repeat (8) begin
            @(negedge i_clk);
            check_value("o_ip", o_ip, '0);
        end
        set_thr(0, 3);
        settle();
        check_value("o_ip", o_ip, expected_ip());
        claim(0);
        report_test("4 threshold");

        apply_reset();
        set_prio(12, 6);
        set_enable(1, 32'h1 << 12);
        set_thr(1, 1);
        @(negedge i_clk);
        i_irq[12] = 1'b1;
        claim(1);
        settle();
        read_expect(PEND_ADDR, m_pend, "pending in service");
        check_value("o_ip", o_ip, expected_ip());
        complete(1, 12);
        settle();
        read_expect(PEND_ADDR, m_pend, "pending after complete");
        claim(1);
        complete(1, 12);
        report_test("5 gateway");

        for (int k = 0; k < 16; k++) begin
            src = $random(seed) & 31;
            read_expect(PRIO_BASE + PRIO_STRIDE * 16'(src), m_prio[src], "prio");
        end
        report_test("6 handshake");

        $display("tests run: 6, errors: %0d", errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    initial begin
        #((ACCESSES * 20 + SETTLE) * 10);
        $display("timeout, the tests did not finish within %0d cycles", ACCESSES * 20 + SETTLE);
        $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/plic_top.sv */
// ##########################################################
// plic top level
// register slave, register file, gateways and one arbiter
// per context
// ##########################################################
`timescale 1ns/1ps
`default_nettype none

module plic_top import plic_bus_pkg::*, plic_irq_pkg::*; #(
    parameter int NUM_SRC = 32,             // 2..32, source 0 unused
    parameter int NUM_CTX = 2               // 1..4
) (
    input  wire logic               i_clk,
    input  wire logic               i_nrst,
    input  wire logic               i_req,
    input  wire bus_req_t           i_bus_req,
    output logic                    o_ack,
    output bus_rsp_t                o_bus_rsp,
    input  wire logic [NUM_SRC-1:0] i_irq,
    output wire logic [NUM_CTX-1:0] o_ip
);

    logic               acc;
    bus_req_t           acc_req;
    bus_rsp_t           acc_rsp;
    logic [NUM_SRC-1:0] pending;
    prio_t              prio [NUM_SRC];
    ctx_cfg_t           ctx_cfg [NUM_CTX];
    src_id_t            claim_id [NUM_CTX];
    gw_cmd_t            gw_cmd;

    plic_reg_slave u_slave (
        .i_clk     (i_clk),
        .i_nrst    (i_nrst),
        .i_req     (i_req),
        .i_bus_req (i_bus_req),
        .o_ack     (o_ack),
        .o_bus_rsp (o_bus_rsp),
        .o_acc     (acc),
        .o_acc_req (acc_req),
        .i_acc_rsp (acc_rsp)
    );

    plic_regfile #(.NUM_SRC(NUM_SRC), .NUM_CTX(NUM_CTX)) u_regs (
        .i_clk      (i_clk),
        .i_nrst     (i_nrst),
        .i_acc      (acc),
        .i_acc_req  (acc_req),
        .o_acc_rsp  (acc_rsp),
        .i_pending  (pending),
        .i_claim_id (claim_id),
        .o_prio     (prio),
        .o_ctx_cfg  (ctx_cfg),
        .o_gw_cmd   (gw_cmd)
    );

    plic_gateway #(.NUM_SRC(NUM_SRC)) u_gateway (
        .i_clk     (i_clk),
        .i_nrst    (i_nrst),
        .i_irq     (i_irq),
        .i_gw_cmd  (gw_cmd),
        .o_pending (pending)
    );

    for (genvar n = 0; n < NUM_CTX; n++) begin : g_ctx
        plic_target #(.NUM_SRC(NUM_SRC)) u_target (
            .i_clk      (i_clk),
            .i_nrst     (i_nrst),
            .i_pending  (pending),
            .i_prio     (prio),
            .i_cfg      (ctx_cfg[n]),
            .o_claim_id (claim_id[n]),
            .o_ip       (o_ip[n])
        );
    end

endmodule

`default_nettype wire

/* verilog/plic_target.sv */
// ##########################################################
// plic target
// two-stage arbiter for one context: eligible priorities,
// then the highest-level id, plus the registered ip line
// ##########################################################
`timescale 1ns/1ps
`default_nettype none

module plic_target import plic_irq_pkg::*; #(
    parameter int NUM_SRC = 32
) (
    input  wire logic               i_clk,
    input  wire logic               i_nrst,
    input  wire logic [NUM_SRC-1:0] i_pending,
    input  wire prio_t              i_prio [NUM_SRC],
    input  wire ctx_cfg_t           i_cfg,
    output src_id_t                 o_claim_id,
    output logic                    o_ip
);

    prio_t              elig_prio_d [NUM_SRC];
    logic [NUM_LVL-1:0] lvl_mask_d;
    prio_t              elig_prio_q [NUM_SRC];
    logic [NUM_LVL-1:0] lvl_mask_q;
    prio_t              top_lvl;
    src_id_t            sel_id;
    src_id_t            claim_id_q;
    logic               ip_q;

    // stage 1 keeps pending, enabled sources above the threshold
    always_comb begin
        lvl_mask_d = '0;
        elig_prio_d[0] = '0;
        for (int i = 1; i < NUM_SRC; i++) begin
            elig_prio_d[i] = '0;
            if (i_pending[i] && i_cfg.enable[i] && (i_prio[i] > i_cfg.threshold)) begin
                elig_prio_d[i]          = i_prio[i];
                lvl_mask_d[i_prio[i]]   = 1'b1;
            end
        end
    end

    // stage 2
    always_comb begin
        top_lvl = '0;
        for (int l = 1; l < NUM_LVL; l++) begin
            if (lvl_mask_q[l]) begin
                top_lvl = prio_t'(l);
            end
        end
        sel_id = '0;
        for (int i = 1; i < NUM_SRC; i++) begin
            if ((top_lvl != '0) && (elig_prio_q[i] == top_lvl)) begin
                sel_id = src_id_t'(i);          // later index wins a tie
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            elig_prio_q <= '{default: '0};
            lvl_mask_q  <= '0;
            claim_id_q  <= '0;
            ip_q        <= 1'b0;
        end else begin
            elig_prio_q <= elig_prio_d;
            lvl_mask_q  <= lvl_mask_d;
            claim_id_q  <= sel_id;
            ip_q        <= |claim_id_q;         // one edge behind the id
        end
    end

    assign o_claim_id = claim_id_q;
    assign o_ip       = ip_q;

endmodule

`default_nettype wire

/* verilog/plic_gateway.sv */
// ##########################################################
// plic gateways
// level sources latch pending, then stay masked while the
// claimed interrupt is in service
// ##########################################################
`timescale 1ns/1ps
`default_nettype none

module plic_gateway import plic_irq_pkg::*; #(
    parameter int NUM_SRC = 32
) (
    input  wire logic               i_clk,
    input  wire logic               i_nrst,
    input  wire logic [NUM_SRC-1:0] i_irq,
    input  wire gw_cmd_t            i_gw_cmd,
    output logic [NUM_SRC-1:0]      o_pending
);

    logic [NUM_SRC-1:0] pend_q;
    logic [NUM_SRC-1:0] insvc_q;
    logic [NUM_SRC-1:0] claim_sel;
    logic [NUM_SRC-1:0] done_sel;

    always_comb begin
        for (int i = 0; i < NUM_SRC; i++) begin
            claim_sel[i] = i_gw_cmd.claim && (i_gw_cmd.id == src_id_t'(i));
            done_sel[i]  = i_gw_cmd.complete && (i_gw_cmd.id == src_id_t'(i));
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            pend_q  <= '0;
            insvc_q <= '0;
        end else begin
            for (int i = 1; i < NUM_SRC; i++) begin    // bit 0 stays at zero
                if (claim_sel[i]) begin
                    pend_q[i]  <= 1'b0;
                    insvc_q[i] <= 1'b1;
                end else begin
                    if (i_irq[i] && !pend_q[i] && !insvc_q[i]) begin
                        pend_q[i] <= 1'b1;
                    end
                    if (done_sel[i]) begin
                        insvc_q[i] <= 1'b0;     // a source still high pends again
                    end
                end
            end
        end
    end

    assign o_pending = pend_q;

endmodule

`default_nettype wire

/* verilog/plic_regfile.sv */
// ##########################################################
// plic register file
// map decode, priority/enable/threshold storage, readback
// and claim/complete commands towards the gateways
// ##########################################################
`timescale 1ns/1ps
`default_nettype none

module plic_regfile import plic_bus_pkg::*, plic_irq_pkg::*; #(
    parameter int NUM_SRC = 32,
    parameter int NUM_CTX = 2
) (
    input  wire logic               i_clk,
    input  wire logic               i_nrst,
    input  wire logic               i_acc,
    input  wire bus_req_t           i_acc_req,
    output bus_rsp_t                o_acc_rsp,
    input  wire logic [NUM_SRC-1:0] i_pending,
    input  wire src_id_t            i_claim_id [NUM_CTX],
    output prio_t                   o_prio [NUM_SRC],
    output ctx_cfg_t                o_ctx_cfg [NUM_CTX],
    output gw_cmd_t                 o_gw_cmd
);

    // sources 1..NUM_SRC-1 exist, bit 0 never does
    localparam logic [MAX_SRC-1:0] SRC_MASK = MAX_SRC'((64'd1 << NUM_SRC) - 64'd2);

    prio_t    prio_q [NUM_SRC];
    ctx_cfg_t ctx_q [NUM_CTX];

    logic [NUM_SRC-1:0] prio_hit;
    logic               pend_hit;
    logic [NUM_CTX-1:0] en_hit;
    logic [NUM_CTX-1:0] thr_hit;
    logic [NUM_CTX-1:0] clm_hit;

    function automatic logic [13:0] word_of(input logic [15:0] a);
        return a[15:2];
    endfunction

    // decode on word addresses, byte lanes are ignored
    always_comb begin
        logic [13:0] word;
        word     = word_of(i_acc_req.addr);
        pend_hit = (word == word_of(PEND_ADDR));
        for (int i = 0; i < NUM_SRC; i++) begin
            prio_hit[i] = (word == word_of(PRIO_BASE + PRIO_STRIDE * 16'(i)));
        end
        for (int n = 0; n < NUM_CTX; n++) begin
            en_hit[n]  = (word == word_of(ENABLE_BASE + ENABLE_STRIDE * 16'(n)));
            thr_hit[n] = (word == word_of(CTX_BASE + CTX_STRIDE * 16'(n)));
            clm_hit[n] = (word == word_of(CTX_BASE + CTX_STRIDE * 16'(n) + CLAIM_OFS));
        end
    end

    always_comb begin
        o_acc_rsp = '0;
        for (int i = 0; i < NUM_SRC; i++) begin
            if (prio_hit[i]) begin
                o_acc_rsp.rdata = 32'(prio_q[i]);       // source 0 is always zero
            end
        end
        if (pend_hit) begin
            o_acc_rsp.rdata = 32'(i_pending);
        end
        for (int n = 0; n < NUM_CTX; n++) begin
            if (en_hit[n]) begin
                o_acc_rsp.rdata = 32'(ctx_q[n].enable);
            end
            if (thr_hit[n]) begin
                o_acc_rsp.rdata = 32'(ctx_q[n].threshold);
            end
            if (clm_hit[n]) begin
                o_acc_rsp.rdata = 32'(i_claim_id[n]);
            end
        end
        o_acc_rsp.err = ~|{prio_hit, pend_hit, en_hit, thr_hit, clm_hit};
    end

    // claim only when the context really has a winner
    always_comb begin
        o_gw_cmd = '0;
        for (int n = 0; n < NUM_CTX; n++) begin
            if (i_acc && clm_hit[n]) begin
                if (i_acc_req.write) begin
                    o_gw_cmd.complete = 1'b1;
                    o_gw_cmd.id       = i_acc_req.wdata[ID_W-1:0];
                end else if (i_claim_id[n] != '0) begin
                    o_gw_cmd.claim = 1'b1;
                    o_gw_cmd.id    = i_claim_id[n];
                end
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            prio_q <= '{default: '0};
            ctx_q  <= '{default: '0};
        end else if (i_acc && i_acc_req.write) begin
            for (int i = 1; i < NUM_SRC; i++) begin
                if (prio_hit[i]) begin
                    prio_q[i] <= i_acc_req.wdata[PRIO_W-1:0];
                end
            end
            for (int n = 0; n < NUM_CTX; n++) begin
                if (en_hit[n]) begin
                    ctx_q[n].enable <= i_acc_req.wdata[MAX_SRC-1:0] & SRC_MASK;
                end
                if (thr_hit[n]) begin
                    ctx_q[n].threshold <= i_acc_req.wdata[PRIO_W-1:0];
                end
            end
        end
    end

    assign o_prio    = prio_q;
    assign o_ctx_cfg = ctx_q;

endmodule

`default_nettype wire

/* verilog/plic_reg_slave.sv */
// ##########################################################
// plic register slave
// four-phase req/ack port, one access strobe per handshake
// ##########################################################
`timescale 1ns/1ps
`default_nettype none

module plic_reg_slave import plic_bus_pkg::*; (
    input  wire logic     i_clk,
    input  wire logic     i_nrst,
    input  wire logic     i_req,
    input  wire bus_req_t i_bus_req,
    output logic          o_ack,
    output bus_rsp_t      o_bus_rsp,
    output logic          o_acc,
    output bus_req_t      o_acc_req,
    input  wire bus_rsp_t i_acc_rsp
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ACCESS,                          // strobe cycle
        ST_ACK,                             // response presented
        ST_HOLD                             // waiting for the master to let go
    } state_t;

    state_t   state_q;
    bus_req_t req_q;
    bus_rsp_t rsp_q;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state_q <= ST_IDLE;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (i_req) begin
                        state_q <= ST_ACCESS;
                    end
                end
                ST_ACCESS: state_q <= ST_ACK;
                ST_ACK: state_q <= i_req ? ST_HOLD : ST_IDLE;
                ST_HOLD: begin
                    if (!i_req) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // request held for the strobe cycle
    always_ff @(posedge i_clk) begin
        if (state_q == ST_IDLE && i_req) begin
            req_q <= i_bus_req;
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            rsp_q <= '0;
        end else if (state_q == ST_ACCESS) begin
            rsp_q <= i_acc_rsp;             // stays put until the next access
        end
    end

    assign o_acc     = (state_q == ST_ACCESS);
    assign o_acc_req = req_q;
    assign o_ack     = (state_q == ST_ACK) || (state_q == ST_HOLD);
    assign o_bus_rsp = rsp_q;

endmodule

`default_nettype wire

/* verilog/plic_irq_pkg.sv */
// ##########################################################
// plic interrupt definitions
// priority and source id types, per-context configuration
// and the command from the register file to the gateways
// ##########################################################
`default_nettype none

package plic_irq_pkg;

    localparam int PRIO_W  = 4;
    localparam int ID_W    = 5;
    localparam int MAX_SRC = 32;
    localparam int NUM_LVL = 2 ** PRIO_W;   // priority levels seen by the arbiter

    typedef logic [PRIO_W-1:0] prio_t;
    typedef logic [ID_W-1:0]   src_id_t;

    // bits at and above NUM_SRC are kept zero by the register file
    typedef struct packed {
        prio_t              threshold;
        logic [MAX_SRC-1:0] enable;
    } ctx_cfg_t;

    typedef struct packed {
        logic    claim;                     // clear pending, enter service
        logic    complete;                  // leave service
        src_id_t id;
    } gw_cmd_t;

endpackage

`default_nettype wire

/* verilog/plic_bus_pkg.sv */
// ##########################################################
// plic register bus definitions
// request/response structs of the 32-bit req/ack port and
// the byte offsets of the controller register map
// ##########################################################
`default_nettype none

package plic_bus_pkg;

    typedef struct packed {
        logic        write;                 // 1 = write, 0 = read
        logic [15:0] addr;                  // byte address
        logic [31:0] wdata;
    } bus_req_t;

    typedef struct packed {
        logic [31:0] rdata;
        logic        err;                   // unmapped address
    } bus_rsp_t;

    // source priorities, one word per source
    localparam logic [15:0] PRIO_BASE     = 16'h0000;
    localparam logic [15:0] PRIO_STRIDE   = 16'h0004;

    // pending bits, read-only
    localparam logic [15:0] PEND_ADDR     = 16'h1000;

    // enable word per context
    localparam logic [15:0] ENABLE_BASE   = 16'h2000;
    localparam logic [15:0] ENABLE_STRIDE = 16'h0080;

    // threshold at the context base, claim/complete one word above
    localparam logic [15:0] CTX_BASE      = 16'h3000;
    localparam logic [15:0] CTX_STRIDE    = 16'h0010;
    localparam logic [15:0] CLAIM_OFS     = 16'h0004;

endpackage

`default_nettype wire
